// ==== all.f ====
verilog/softmc_pkg.sv
verilog/instr_mem.sv
verilog/cmd_encoder.sv
verilog/odt_gen.sv
verilog/readback_buf.sv
verilog/seq_control.sv
verilog/softmc_core.sv
verif/softmc_checker.sv
verif/tb_softmc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the softmc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_softmc -f all.f

out=$(./obj_dir/Vtb_softmc)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

// ==== verif/tb_softmc.sv ====
`timescale 1ns/1ns

module tb_softmc;
  import softmc_pkg::*;

  localparam int RD_LAT      = 7;
  localparam int NUM_PROGS   = 5;
  localparam int MAX_WORDS   = 40;
  localparam int SEED        = 92;
  localparam int DONE_LIMIT  = 2000;
  localparam int DRAIN_LIMIT = 64;

  logic                      c0_ddr4_clk;
  logic                      rst_n;
  logic                      instr_valid;
  logic                      instr_last;
  instr_u                    instr_data;
  logic                      rd_valid = 1'b0;
  logic [RD_DATA_WIDTH-1:0]  rd_data = '0;
  logic                      ddr_act_n;
  logic                      ddr_cs_n;
  logic [ROW_ADDR_WIDTH-1:0] ddr_adr;
  logic [BG_WIDTH-1:0]       ddr_bg;
  logic [BANK_WIDTH-1:0]     ddr_ba;
  logic                      ddr_odt;
  logic                      c2h_valid;
  logic [RD_DATA_WIDTH-1:0]  c2h_data;
  logic                      c2h_last;
  logic                      seq_done;

  int     cyc = 0;
  int     rd_due_q[$];
  int     check_count;
  int     err_count;
  int     timeout_count = 0;
  instr_u prog [MAX_WORDS];
  int     prog_len;
  int     prog_reads;

  softmc_core UUT (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_last  (instr_last),
    .instr_data  (instr_data),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .ddr_act_n   (ddr_act_n),
    .ddr_cs_n    (ddr_cs_n),
    .ddr_adr     (ddr_adr),
    .ddr_bg      (ddr_bg),
    .ddr_ba      (ddr_ba),
    .ddr_odt     (ddr_odt),
    .c2h_valid   (c2h_valid),
    .c2h_data    (c2h_data),
    .c2h_last    (c2h_last),
    .seq_done    (seq_done)
  );

  softmc_checker u_checker (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_last  (instr_last),
    .instr_data  (instr_data),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .ddr_act_n   (ddr_act_n),
    .ddr_cs_n    (ddr_cs_n),
    .ddr_adr     (ddr_adr),
    .ddr_bg      (ddr_bg),
    .ddr_ba      (ddr_ba),
    .ddr_odt     (ddr_odt),
    .c2h_valid   (c2h_valid),
    .c2h_data    (c2h_data),
    .c2h_last    (c2h_last),
    .seq_done    (seq_done),
    .check_count (check_count),
    .err_count   (err_count)
  );

  initial begin
    c0_ddr4_clk = 1'b0;
    forever #4 c0_ddr4_clk = ~c0_ddr4_clk;
  end

  // Memory side, one data word per RD seen on the pins
  always @(posedge c0_ddr4_clk) begin
    if (!ddr_cs_n && ddr_act_n && ddr_adr[16:14] == 3'b101) begin
      rd_due_q.push_back(cyc + RD_LAT - 1);
    end
    if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
      void'(rd_due_q.pop_front());
      rd_valid <= 1'b1;
      rd_data  <= {$urandom, $urandom};
    end else begin
      rd_valid <= 1'b0;
    end
    cyc <= cyc + 1;
  end

  task automatic gen_program(input bit allow_reads);
    int     body;
    instr_u w;
    body       = 1 + int'($urandom % (MAX_WORDS - 2));
    prog_reads = 0;
    for (int i = 0; i < body; i++) begin
      w = $urandom;
      case ($urandom % 7)
        0: w.cmd.opcode = OP_ACT;
        1: w.cmd.opcode = OP_RD;
        2: w.cmd.opcode = OP_WR;
        3: w.cmd.opcode = OP_PRE;
        4: w.cmd.opcode = OP_REF;
        5: w.cmd.opcode = OP_NOP;
        default: w.cmd.opcode = OP_WAIT;
      endcase
      // Readback buffer holds at most BUF_DEPTH words
      if (w.cmd.opcode == OP_RD) begin
        if (!allow_reads || prog_reads == BUF_DEPTH) begin
          w.cmd.opcode = OP_PRE;
        end else begin
          prog_reads++;
        end
      end
      if (w.cmd.opcode == OP_WAIT) begin
        w.ctrl.count = WAIT_WIDTH'($urandom % 6);
        w.ctrl.spare = '0;
      end
      prog[i] = w;
    end
    // Last reads return before END starts the drain
    w            = '0;
    w.ctrl.opcode = OP_WAIT;
    w.ctrl.count  = WAIT_WIDTH'(20);
    prog[body]    = w;
    w             = '0;
    w.ctrl.opcode = OP_END;
    prog[body+1]  = w;
    prog_len      = body + 2;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge c0_ddr4_clk);
      instr_valid <= 1'b1;
      instr_data  <= prog[i];
      instr_last  <= (i == prog_len - 1);
    end
    @(posedge c0_ddr4_clk);
    instr_valid <= 1'b0;
    instr_last  <= 1'b0;
  endtask

  // Either seq_done or the final readback word
  task automatic wait_event(input bit drain, input int limit, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < limit) begin
      @(posedge c0_ddr4_clk);
      ok = drain ? (c2h_valid && c2h_last) : seq_done;
      n++;
    end
    if (!ok) begin
      timeout_count++;
      $display("Timeout: no %s within %0d cycles",
               drain ? "final readback word" : "seq_done", limit);
    end
  endtask

  initial begin
    bit ok;
    void'($urandom(SEED));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr_last  = 1'b0;
    instr_data  = '0;
    ok          = 1'b1;
    repeat (10) @(posedge c0_ddr4_clk);
    rst_n <= 1'b1;
    for (int p = 0; p < NUM_PROGS && ok; p++) begin
      // Program 2 has no reads, so nothing may be drained
      gen_program(p != 2);
      load_program();
      wait_event(1'b0, DONE_LIMIT, ok);
      if (ok && prog_reads > 0) begin
        wait_event(1'b1, DRAIN_LIMIT, ok);
      end
      repeat (4) @(posedge c0_ddr4_clk);
    end
    $display("Checks: %0d  mismatches: %0d  timeouts: %0d",
             check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0 && check_count > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verif/softmc_checker.sv ====
`timescale 1ns/1ns

module softmc_checker (
  input  logic                                    c0_ddr4_clk,
  input  logic                                    rst_n,
  input  logic                                    instr_valid,
  input  logic                                    instr_last,
  input  softmc_pkg::instr_u                      instr_data,
  input  logic                                    rd_valid,
  input  logic [softmc_pkg::RD_DATA_WIDTH-1:0]    rd_data,
  input  logic                                    ddr_act_n,
  input  logic                                    ddr_cs_n,
  input  logic [softmc_pkg::ROW_ADDR_WIDTH-1:0]   ddr_adr,
  input  logic [softmc_pkg::BG_WIDTH-1:0]         ddr_bg,
  input  logic [softmc_pkg::BANK_WIDTH-1:0]       ddr_ba,
  input  logic                                    ddr_odt,
  input  logic                                    c2h_valid,
  input  logic [softmc_pkg::RD_DATA_WIDTH-1:0]    c2h_data,
  input  logic                                    c2h_last,
  input  logic                                    seq_done,
  output int                                      check_count,
  output int                                      err_count
);
  import softmc_pkg::*;

  localparam int ODT_SPAN = ODT_WR_DEL + ODT_WR_DUR;

  int                       cyc = 0;
  int                       n_checks = 0;
  int                       n_errors = 0;
  int                       load_idx = 0;
  int                       done_time = -1;
  int                       drain_start = 0;
  instr_u                   prog [IMEM_DEPTH];
  int                       exp_time_q[$];
  instr_u                   exp_cmd_q[$];
  logic [RD_DATA_WIDTH-1:0] capture_q[$];
  logic [RD_DATA_WIDTH-1:0] drain_q[$];
  logic [ODT_SPAN-1:0]      wr_hist = '0;

  assign check_count = n_checks;
  assign err_count   = n_errors;

  // Expected DDR4 address pins with ras_n/cas_n/we_n on A16..A14 and A10 low
  function automatic logic [16:0] expected_adr(instr_u w);
    logic [16:0] a;
    case (w.cmd.opcode)
      OP_ACT:  a = w.cmd.addr;
      OP_RD:   a = {3'b101, 4'b0000, w.cmd.addr[9:0]};
      OP_WR:   a = {3'b100, 4'b0000, w.cmd.addr[9:0]};
      OP_PRE:  a = {3'b010, 14'd0};
      OP_REF:  a = {3'b001, 14'd0};
      default: a = '0;
    endcase
    return a;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp_v,
                         input logic [63:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
    end
  endtask

  // Pin cycle of every command takes one slot per word and n+1 for WAIT n
  task automatic build_schedule(input int start, input int len);
    int      t;
    opcode_e op;
    t = start;
    for (int i = 0; i < len; i++) begin
      op = prog[i].ctrl.opcode;
      if (op == OP_WAIT) begin
        t += int'(prog[i].ctrl.count) + 1;
      end else if (op == OP_END) begin
        done_time = t;
        break;
      end else begin
        if (op != OP_NOP) begin
          exp_time_q.push_back(t);
          exp_cmd_q.push_back(prog[i]);
        end
        t++;
      end
    end
  endtask

  always @(posedge c0_ddr4_clk) begin
    bit     cmd_now;
    bit     exp_odt;
    instr_u w;
    cyc = cyc + 1;
    if (!rst_n) begin
      load_idx  = 0;
      done_time = -1;
      wr_hist   = '0;
      exp_time_q.delete();
      exp_cmd_q.delete();
      capture_q.delete();
      drain_q.delete();
    end else begin
      if (instr_valid) begin
        prog[load_idx] = instr_data;
        load_idx++;
        // Enter run, fetch, then register the pins
        if (instr_last) begin
          build_schedule(cyc + 3, load_idx);
          load_idx = 0;
        end
      end
      if (rd_valid) begin
        capture_q.push_back(rd_data);
      end

      cmd_now = (exp_time_q.size() > 0) && (exp_time_q[0] == cyc);
      if (cmd_now) begin
        void'(exp_time_q.pop_front());
        w = exp_cmd_q.pop_front();
        compare("ddr_cs_n", 0, ddr_cs_n);
        compare("ddr_act_n", w.cmd.opcode != OP_ACT, ddr_act_n);
        compare("ddr_adr", expected_adr(w), ddr_adr);
        compare("ddr_bg", w.cmd.bg, ddr_bg);
        compare("ddr_ba", w.cmd.bank, ddr_ba);
      end else begin
        compare("ddr_cs_n", 1, ddr_cs_n);
        compare("ddr_act_n", 1, ddr_act_n);
      end

      // Every write opens an ODT window and later writes extend it
      wr_hist = {wr_hist[ODT_SPAN-2:0], cmd_now && (w.cmd.opcode == OP_WR)};
      exp_odt = |wr_hist[ODT_SPAN-1:ODT_WR_DEL];
      compare("ddr_odt", exp_odt, ddr_odt);

      compare("seq_done", cyc == done_time, seq_done);
      if (cyc == done_time) begin
        drain_q = capture_q;
        capture_q.delete();
        drain_start = cyc + 1;
      end

      if (drain_q.size() > 0 && cyc >= drain_start) begin
        compare("c2h_valid", 1, c2h_valid);
        compare("c2h_data", drain_q[0], c2h_data);
        compare("c2h_last", drain_q.size() == 1, c2h_last);
        void'(drain_q.pop_front());
      end else begin
        compare("c2h_valid", 0, c2h_valid);
        compare("c2h_last", 0, c2h_last);
      end
    end
  end

endmodule

// ==== verilog/softmc_core.sv ====
`timescale 1ns/1ns

module softmc_core (
  input  logic                                    c0_ddr4_clk,
  input  logic                                    rst_n,
  input  logic                                    instr_valid,
  input  logic                                    instr_last,
  input  softmc_pkg::instr_u                      instr_data,
  input  logic                                    rd_valid,
  input  logic [softmc_pkg::RD_DATA_WIDTH-1:0]    rd_data,
  output logic                                    ddr_act_n,
  output logic                                    ddr_cs_n,
  output logic [softmc_pkg::ROW_ADDR_WIDTH-1:0]   ddr_adr,
  output logic [softmc_pkg::BG_WIDTH-1:0]         ddr_bg,
  output logic [softmc_pkg::BANK_WIDTH-1:0]       ddr_ba,
  output logic                                    ddr_odt,
  output logic                                    c2h_valid,
  output logic [softmc_pkg::RD_DATA_WIDTH-1:0]    c2h_data,
  output logic                                    c2h_last,
  output logic                                    seq_done
);
  import softmc_pkg::*;

  // Sequencer <-> instruction memory
  logic                       wr_en;
  logic [IMEM_ADDR_WIDTH-1:0] wr_addr;
  instr_u                     wr_data;
  logic [IMEM_ADDR_WIDTH-1:0] rd_addr;
  instr_u                     fetch_data;

  // Sequencer -> command path
  logic   issue_valid;
  instr_u issue_instr;
  logic   wr_cmd;
  logic   flush;

  seq_control u_seq_control (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_last  (instr_last),
    .instr_data  (instr_data),
    .fetch_data  (fetch_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .issue_valid (issue_valid),
    .issue_instr (issue_instr),
    .flush       (flush),
    .seq_done    (seq_done)
  );

  instr_mem u_instr_mem (
    .c0_ddr4_clk (c0_ddr4_clk),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (fetch_data)
  );

  cmd_encoder u_cmd_encoder (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_instr (issue_instr),
    .ddr_act_n   (ddr_act_n),
    .ddr_cs_n    (ddr_cs_n),
    .ddr_adr     (ddr_adr),
    .ddr_bg      (ddr_bg),
    .ddr_ba      (ddr_ba),
    .wr_cmd      (wr_cmd)
  );

  odt_gen u_odt_gen (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n       (rst_n),
    .wr_cmd      (wr_cmd),
    .ddr_odt     (ddr_odt)
  );

  readback_buf u_readback_buf (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n       (rst_n),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .flush       (flush),
    .c2h_valid   (c2h_valid),
    .c2h_data    (c2h_data),
    .c2h_last    (c2h_last)
  );

endmodule

// ==== verilog/seq_control.sv ====
`timescale 1ns/1ns

module seq_control (
  input  logic                                     c0_ddr4_clk,
  input  logic                                     rst_n,
  input  logic                                     instr_valid,
  input  logic                                     instr_last,
  input  softmc_pkg::instr_u                       instr_data,
  input  softmc_pkg::instr_u                       fetch_data,
  output logic                                     wr_en,
  output logic [softmc_pkg::IMEM_ADDR_WIDTH-1:0]   wr_addr,
  output softmc_pkg::instr_u                       wr_data,
  output logic [softmc_pkg::IMEM_ADDR_WIDTH-1:0]   rd_addr,
  output logic                                     issue_valid,
  output softmc_pkg::instr_u                       issue_instr,
  output logic                                     flush,
  output logic                                     seq_done
);
  import softmc_pkg::*;

  logic                       running;
  logic                       fetch_valid;
  logic [IMEM_ADDR_WIDTH-1:0] load_addr;
  logic [IMEM_ADDR_WIDTH-1:0] pc;
  logic [WAIT_WIDTH-1:0]      wait_cnt;
  opcode_e                    op;
  logic                       exec;
  logic                       wait_exec;
  logic                       end_exec;
  logic                       pc_hold;

  // Host load port goes straight to the instruction memory
  assign wr_en   = instr_valid && !running;
  assign wr_addr = load_addr;
  assign wr_data = instr_data;

  assign rd_addr = pc;

  // Opcode is read through the control view
  assign op = fetch_data.ctrl.opcode;

  // Fetched word executes once any pending WAIT has expired
  assign exec      = fetch_valid && (wait_cnt == '0);
  assign wait_exec = exec && (op == OP_WAIT);
  assign end_exec  = exec && (op == OP_END);

  // Keep re-reading the word after a WAIT until the last stall cycle
  assign pc_hold = (wait_exec && (fetch_data.ctrl.count != '0)) ||
                   (wait_cnt > WAIT_WIDTH'(1));

  assign issue_valid = exec && !(op inside {OP_NOP, OP_WAIT, OP_END});
  assign issue_instr = fetch_data;

  assign flush = seq_done;

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n) begin
      running     <= 1'b0;
      fetch_valid <= 1'b0;
      load_addr   <= '0;
      pc          <= '0;
      wait_cnt    <= '0;
      seq_done    <= 1'b0;
    end else begin
      seq_done    <= end_exec;
      fetch_valid <= running && !end_exec;

      // Last word of a program load kicks off execution
      if (wr_en) begin
        if (instr_last) begin
          load_addr <= '0;
          pc        <= '0;
          running   <= 1'b1;
        end else begin
          load_addr <= load_addr + 1'b1;
        end
      end

      if (running) begin
        if (end_exec) begin
          running <= 1'b0;
        end
        if (!pc_hold) begin
          pc <= pc + 1'b1;
        end
        if (wait_exec) begin
          wait_cnt <= fetch_data.ctrl.count;
        end else if (wait_cnt != '0) begin
          wait_cnt <= wait_cnt - 1'b1;
        end
      end
    end
  end

  // Host has no back-pressure and must stay quiet while a program runs
  a_no_load_while_running: assert property (
    @(posedge c0_ddr4_clk) disable iff (!rst_n)
    running |-> !instr_valid
  );

  // A held PC leaves a stale word in fetch, which must not issue
  a_no_issue_in_wait: assert property (
    @(posedge c0_ddr4_clk) disable iff (!rst_n)
    pc_hold |=> !issue_valid
  );

endmodule

// ==== verilog/readback_buf.sv ====
`timescale 1ns/1ns

module readback_buf (
  input  logic                                   c0_ddr4_clk,
  input  logic                                   rst_n,
  input  logic                                   rd_valid,
  input  logic [softmc_pkg::RD_DATA_WIDTH-1:0]   rd_data,
  input  logic                                   flush,
  output logic                                   c2h_valid,
  output logic [softmc_pkg::RD_DATA_WIDTH-1:0]   c2h_data,
  output logic                                   c2h_last
);
  import softmc_pkg::*;

  logic [RD_DATA_WIDTH-1:0]  mem [BUF_DEPTH];
  logic [BUF_ADDR_WIDTH-1:0] wr_ptr;
  logic [BUF_ADDR_WIDTH-1:0] rd_ptr;
  logic [BUF_ADDR_WIDTH:0]   count;
  logic                      draining;
  logic                      pop;
  logic                      pop_last;

  assign pop      = (flush || draining) && (count != '0);
  assign pop_last = pop && (count == (BUF_ADDR_WIDTH+1)'(1));

  always_ff @(posedge c0_ddr4_clk) begin
    if (rd_valid) begin
      mem[wr_ptr] <= rd_data;
    end
    if (pop) begin
      c2h_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      draining  <= 1'b0;
      c2h_valid <= 1'b0;
      c2h_last  <= 1'b0;
    end else begin
      wr_ptr    <= wr_ptr + BUF_ADDR_WIDTH'(rd_valid);
      rd_ptr    <= rd_ptr + BUF_ADDR_WIDTH'(pop);
      count     <= count + (BUF_ADDR_WIDTH+1)'(rd_valid) - (BUF_ADDR_WIDTH+1)'(pop);
      // Drain runs until the final stored word goes out
      draining  <= pop && !pop_last;
      c2h_valid <= pop;
      c2h_last  <= pop_last;
    end
  end

  a_no_overflow: assert property (
    @(posedge c0_ddr4_clk) disable iff (!rst_n)
    rd_valid |-> (count != (BUF_ADDR_WIDTH+1)'(BUF_DEPTH))
  );

  a_no_read_in_drain: assert property (
    @(posedge c0_ddr4_clk) disable iff (!rst_n)
    (flush || draining) |-> !rd_valid
  );

endmodule

// ==== verilog/odt_gen.sv ====
`timescale 1ns/1ns

module odt_gen (
  input  logic c0_ddr4_clk,
  input  logic rst_n,
  input  logic wr_cmd,
  output logic ddr_odt
);
  import softmc_pkg::*;

  // The ODT flop itself is the last stage of the delay
  logic [ODT_WR_DEL-2:0]    wr_dly;
  logic [ODT_CNT_WIDTH-1:0] dur_cnt;
  logic                     odt_start;

  assign odt_start = wr_dly[ODT_WR_DEL-2];

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n) begin
      wr_dly  <= '0;
      dur_cnt <= '0;
      ddr_odt <= 1'b0;
    end else begin
      wr_dly <= {wr_dly[ODT_WR_DEL-3:0], wr_cmd};
      // A later write restarts the window so back to back bursts merge
      if (odt_start) begin
        dur_cnt <= ODT_CNT_WIDTH'(ODT_WR_DUR - 1);
        ddr_odt <= 1'b1;
      end else if (dur_cnt != '0) begin
        dur_cnt <= dur_cnt - 1'b1;
        ddr_odt <= 1'b1;
      end else begin
        ddr_odt <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/cmd_encoder.sv ====
`timescale 1ns/1ns

module cmd_encoder (
  input  logic                                    c0_ddr4_clk,
  input  logic                                    rst_n,
  input  logic                                    issue_valid,
  input  softmc_pkg::instr_u                      issue_instr,
  output logic                                    ddr_act_n,
  output logic                                    ddr_cs_n,
  output logic [softmc_pkg::ROW_ADDR_WIDTH-1:0]   ddr_adr,
  output logic [softmc_pkg::BG_WIDTH-1:0]         ddr_bg,
  output logic [softmc_pkg::BANK_WIDTH-1:0]       ddr_ba,
  output logic                                    wr_cmd
);
  import softmc_pkg::*;

  opcode_e                   op;
  logic [ROW_ADDR_WIDTH-1:0] adr_nxt;

  assign op = issue_instr.cmd.opcode;

  // DDR4 truth table, A10 stays low so no auto precharge and no PRE all
  always_comb begin
    adr_nxt = '0;
    case (op)
      OP_ACT: adr_nxt = issue_instr.cmd.addr;
      OP_RD: begin
        adr_nxt[ROW_ADDR_WIDTH-1 -: 3] = RCW_RD;
        adr_nxt[COL_WIDTH-1:0]         = issue_instr.cmd.addr[COL_WIDTH-1:0];
      end
      OP_WR: begin
        adr_nxt[ROW_ADDR_WIDTH-1 -: 3] = RCW_WR;
        adr_nxt[COL_WIDTH-1:0]         = issue_instr.cmd.addr[COL_WIDTH-1:0];
      end
      OP_PRE:  adr_nxt[ROW_ADDR_WIDTH-1 -: 3] = RCW_PRE;
      OP_REF:  adr_nxt[ROW_ADDR_WIDTH-1 -: 3] = RCW_REF;
      default: adr_nxt = '0;
    endcase
  end

  // Deselect whenever nothing is issued
  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n) begin
      ddr_cs_n  <= 1'b1;
      ddr_act_n <= 1'b1;
      wr_cmd    <= 1'b0;
    end else begin
      ddr_cs_n  <= !issue_valid;
      ddr_act_n <= !(issue_valid && (op == OP_ACT));
      wr_cmd    <= issue_valid && (op == OP_WR);
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (issue_valid) begin
      ddr_adr <= adr_nxt;
      ddr_bg  <= issue_instr.cmd.bg;
      ddr_ba  <= issue_instr.cmd.bank;
    end
  end

  a_act_selected: assert property (
    @(posedge c0_ddr4_clk) disable iff (!rst_n)
    !ddr_act_n |-> !ddr_cs_n
  );

endmodule

// ==== verilog/instr_mem.sv ====
`timescale 1ns/1ns

module instr_mem (
  input  logic                                     c0_ddr4_clk,
  input  logic                                     wr_en,
  input  logic [softmc_pkg::IMEM_ADDR_WIDTH-1:0]   wr_addr,
  input  softmc_pkg::instr_u                       wr_data,
  input  logic [softmc_pkg::IMEM_ADDR_WIDTH-1:0]   rd_addr,
  output softmc_pkg::instr_u                       rd_data
);
  import softmc_pkg::*;

  instr_u mem [IMEM_DEPTH];

  // Load port
  always_ff @(posedge c0_ddr4_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Fetch port, one word per cycle
  always_ff @(posedge c0_ddr4_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== verilog/softmc_pkg.sv ====
package softmc_pkg;

  // Instruction memory
  localparam int INSTR_WIDTH     = 32;
  localparam int IMEM_DEPTH      = 64;
  localparam int IMEM_ADDR_WIDTH = 6;

  // DDR4 command pin widths
  localparam int ROW_ADDR_WIDTH = 17;
  localparam int BG_WIDTH       = 2;
  localparam int BANK_WIDTH     = 2;
  localparam int COL_WIDTH      = 10;

  // Readback path
  localparam int RD_DATA_WIDTH  = 64;
  localparam int BUF_DEPTH      = 16;
  localparam int BUF_ADDR_WIDTH = $clog2(BUF_DEPTH);

  localparam int WAIT_WIDTH = 16;

  // ODT after write, in controller cycles
  localparam int ODT_WR_DEL    = 4;
  localparam int ODT_WR_DUR    = 6;
  localparam int ODT_CNT_WIDTH = $clog2(ODT_WR_DUR);

  // ras_n/cas_n/we_n placed on address bits 16..14
  localparam logic [2:0] RCW_RD  = 3'b101;
  localparam logic [2:0] RCW_WR  = 3'b100;
  localparam logic [2:0] RCW_PRE = 3'b010;
  localparam logic [2:0] RCW_REF = 3'b001;

  localparam int CMD_SPARE_WIDTH  = INSTR_WIDTH - 3 - BG_WIDTH - BANK_WIDTH - ROW_ADDR_WIDTH;
  localparam int CTRL_SPARE_WIDTH = INSTR_WIDTH - 3 - WAIT_WIDTH;

  typedef enum logic [2:0] {
    OP_NOP  = 3'd0,
    OP_ACT  = 3'd1,
    OP_RD   = 3'd2,
    OP_WR   = 3'd3,
    OP_PRE  = 3'd4,
    OP_REF  = 3'd5,
    OP_WAIT = 3'd6,
    OP_END  = 3'd7
  } opcode_e;

  // Same word seen as a DRAM command or as a sequencer control op
  typedef union packed {
    struct packed {
      opcode_e                      opcode;
      logic [BG_WIDTH-1:0]          bg;
      logic [BANK_WIDTH-1:0]        bank;
      logic [ROW_ADDR_WIDTH-1:0]    addr;
      logic [CMD_SPARE_WIDTH-1:0]   spare;
    } cmd;
    struct packed {
      opcode_e                      opcode;
      logic [WAIT_WIDTH-1:0]        count;
      logic [CTRL_SPARE_WIDTH-1:0]  spare;
    } ctrl;
  } instr_u;

endpackage
